// ==== logic/tcb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// TCB subsystem package: bus widths, vector types, controller states
//////////////////////////////////////////////////////////////////////

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned ADR = 10;
  // data width
  localparam int unsigned DAT = 32;
  // byte enables, one per data byte
  localparam int unsigned BEN = DAT / 8;
  // log2 size field
  localparam int unsigned SIZ = 2;
  // write data capture granularity in bytes
  localparam int unsigned GRN = 1;
  // response delay after acceptance, in cycles
  localparam int unsigned DLY = 1;
  // memory depth in words
  localparam int unsigned WRD = 256;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADR-1:0]         adr_t;
  typedef logic [DAT-1:0]         dat_t;
  typedef logic [BEN-1:0]         ben_t;
  // size in bytes is 2**siz
  typedef logic [SIZ-1:0]         siz_t;
  // word index into the array
  typedef logic [$clog2(WRD)-1:0] wix_t;

  // controller FSM, rmw states only used by partial writes
  typedef enum logic [1:0] {
    idle,
    rmw_read,
    rmw_write
  } ctl_state_t;

endpackage

// ==== logic/tcb_bp_slice.sv ====
//////////////////////////////////////////////////////////////////////
// TCB register slice on the back-pressure (ready) path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_bp_slice (
  input  logic          sub,
  input  logic          rst,
  // request from the manager
  input  logic          vld,
  output logic          rdy,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::siz_t siz,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // request toward the controller
  output logic          m_vld,
  input  logic          m_rdy,
  output logic          m_wen,
  output tcb_pkg::adr_t m_adr,
  output tcb_pkg::siz_t m_siz,
  output tcb_pkg::ben_t m_ben,
  output tcb_pkg::dat_t m_wdt
);

  import tcb_pkg::*;

  // held copy of a stalled request
  logic tmp_wen;
  adr_t tmp_adr;
  siz_t tmp_siz;
  ben_t tmp_ben;
  dat_t tmp_wdt;

  //////////////////////////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////////////////////////

  // transfer on our side that the controller did not take
  always_ff @(posedge sub) begin
    if (vld & rdy & ~m_rdy) begin
      tmp_wen <= wen;
      tmp_adr <= adr;
      tmp_siz <= siz;
      tmp_ben <= ben;
      // only enabled chunks, the rest of the data is don't care
      for (int unsigned i = 0; i < BEN; i += GRN) begin
        if (wen & ben[i]) begin
          tmp_wdt[8*i +: 8*GRN] <= wdt[8*i +: 8*GRN];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // forward path
  //////////////////////////////////////////////////////////////////////

  // transparent while ready, held copy otherwise
  assign m_vld = rdy ? vld : 1'b1;
  assign m_wen = rdy ? wen : tmp_wen;
  assign m_adr = rdy ? adr : tmp_adr;
  assign m_siz = rdy ? siz : tmp_siz;
  assign m_ben = rdy ? ben : tmp_ben;
  assign m_wdt = rdy ? wdt : tmp_wdt;

  // registered ready, breaks the combinational path back to the manager
  always_ff @(posedge sub) begin
    if (rst) begin
      rdy <= 1'b1;
    end else if (rdy) begin
      // drop after a transfer the controller refused
      rdy <= ~(vld & ~m_rdy);
    end else begin
      // held request leaves once the controller is ready
      rdy <= m_rdy;
    end
  end

endmodule

// ==== logic/tcb_ctl.sv ====
//////////////////////////////////////////////////////////////////////
// TCB controller: alignment check, RMW sequencing, response timing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_ctl (
  input  logic          sub,
  input  logic          rst,
  // request from the slice
  input  logic          m_vld,
  output logic          m_rdy,
  input  logic          m_wen,
  input  tcb_pkg::adr_t m_adr,
  input  tcb_pkg::siz_t m_siz,
  input  tcb_pkg::ben_t m_ben,
  input  tcb_pkg::dat_t m_wdt,
  // response
  output logic          err,
  output logic          rsp,
  // memory port
  output logic          mem_en,
  output logic          mem_we,
  output tcb_pkg::wix_t mem_wix,
  output tcb_pkg::ben_t mem_ben,
  output tcb_pkg::dat_t mem_wdt,
  output logic          mem_mrg
);

  import tcb_pkg::*;

  ctl_state_t state;
  logic       acc;
  logic       mis;
  logic       prt;
  // response delay line, last stage drives the port
  logic [DLY-1:0] rsp_dly;
  logic [DLY-1:0] err_dly;
  // partial write payload kept across the rmw states
  wix_t hld_wix;
  ben_t hld_ben;
  dat_t hld_wdt;

  // new requests only in idle
  assign m_rdy = (state == idle);
  assign acc   = m_vld & m_rdy;

  // low siz bits of the address must be zero
  assign mis = |(m_adr & ~(adr_t'('1) << m_siz));
  // write with some byte lanes off
  assign prt = m_wen & ~(&m_ben);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle:      if (acc & ~mis & prt) state <= rmw_read;
        rmw_read:  state <= rmw_write;
        rmw_write: state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  // payload, loaded on every acceptance
  always_ff @(posedge sub) begin
    if (acc) begin
      hld_wix <= wix_t'(m_adr[ADR-1:$clog2(BEN)]);
      hld_ben <= m_ben;
      hld_wdt <= m_wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // direct access by default
    mem_en  = 1'b0;
    mem_we  = 1'b0;
    mem_mrg = 1'b0;
    mem_wix = wix_t'(m_adr[ADR-1:$clog2(BEN)]);
    mem_ben = m_ben;
    mem_wdt = m_wdt;
    case (state)
      idle: begin
        // reads and full writes, misaligned leaves memory alone
        if (acc & ~mis & ~prt) begin
          mem_en = 1'b1;
          mem_we = m_wen;
        end
      end
      rmw_read: begin
        mem_en  = 1'b1;
        mem_wix = hld_wix;
      end
      rmw_write: begin
        // merge new lanes into the word read last cycle
        mem_en  = 1'b1;
        mem_we  = 1'b1;
        mem_mrg = 1'b1;
        mem_wix = hld_wix;
        mem_ben = hld_ben;
        mem_wdt = hld_wdt;
      end
      default: begin
        mem_en = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (rst) begin
      rsp_dly <= '0;
      err_dly <= '0;
    end else begin
      rsp_dly[0] <= acc;
      err_dly[0] <= acc & mis;
      for (int unsigned i = 1; i < DLY; i++) begin
        rsp_dly[i] <= rsp_dly[i-1];
        err_dly[i] <= err_dly[i-1];
      end
    end
  end

  assign rsp = rsp_dly[DLY-1];
  assign err = err_dly[DLY-1];

endmodule

// ==== logic/tcb_mem.sv ====
//////////////////////////////////////////////////////////////////////
// single-port word memory with registered read and byte merge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_mem (
  input  logic          sub,
  input  logic          mem_en,
  input  logic          mem_we,
  input  tcb_pkg::wix_t mem_wix,
  input  tcb_pkg::ben_t mem_ben,
  input  tcb_pkg::dat_t mem_wdt,
  input  logic          mem_mrg,
  output tcb_pkg::dat_t mem_rdt
);

  import tcb_pkg::*;

  // whole-word array, no byte write enables
  dat_t mem [WRD];
  // word actually written
  dat_t wr_word;

  //////////////////////////////////////////////////////////////////////
  // byte merge
  //////////////////////////////////////////////////////////////////////

  // old bytes come from the last read, which the rmw read just loaded
  always_comb begin
    for (int unsigned i = 0; i < BEN; i++) begin
      if (mem_mrg & ~mem_ben[i]) begin
        wr_word[8*i +: 8] = mem_rdt[8*i +: 8];
      end else begin
        wr_word[8*i +: 8] = mem_wdt[8*i +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (mem_en & mem_we) begin
      mem[mem_wix] <= wr_word;
    end
  end

  // read data holds through writes, so the merge sees the rmw read
  always_ff @(posedge sub) begin
    if (mem_en & ~mem_we) begin
      mem_rdt <= mem[mem_wix];
    end
  end

endmodule

// ==== logic/tcb_top.sv ====
//////////////////////////////////////////////////////////////////////
// TCB subsystem top: register slice, controller, word memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_top (
  input  logic          sub,
  input  logic          rst,
  // request
  input  logic          vld,
  output logic          rdy,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::siz_t siz,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output tcb_pkg::dat_t rdt,
  output logic          err,
  output logic          rsp
);

  import tcb_pkg::*;

  // slice to controller
  logic m_vld;
  logic m_rdy;
  logic m_wen;
  adr_t m_adr;
  siz_t m_siz;
  ben_t m_ben;
  dat_t m_wdt;

  // controller to memory
  logic mem_en;
  logic mem_we;
  wix_t mem_wix;
  ben_t mem_ben;
  dat_t mem_wdt;
  logic mem_mrg;
  dat_t mem_rdt;

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  tcb_bp_slice u_slice (
    .sub   (sub),
    .rst   (rst),
    .vld   (vld),
    .rdy   (rdy),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .ben   (ben),
    .wdt   (wdt),
    .m_vld (m_vld),
    .m_rdy (m_rdy),
    .m_wen (m_wen),
    .m_adr (m_adr),
    .m_siz (m_siz),
    .m_ben (m_ben),
    .m_wdt (m_wdt)
  );

  tcb_ctl u_ctl (
    .sub     (sub),
    .rst     (rst),
    .m_vld   (m_vld),
    .m_rdy   (m_rdy),
    .m_wen   (m_wen),
    .m_adr   (m_adr),
    .m_siz   (m_siz),
    .m_ben   (m_ben),
    .m_wdt   (m_wdt),
    .err     (err),
    .rsp     (rsp),
    .mem_en  (mem_en),
    .mem_we  (mem_we),
    .mem_wix (mem_wix),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_mrg (mem_mrg)
  );

  tcb_mem u_mem (
    .sub     (sub),
    .mem_en  (mem_en),
    .mem_we  (mem_we),
    .mem_wix (mem_wix),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_mrg (mem_mrg),
    .mem_rdt (mem_rdt)
  );

  // read data straight from the array register
  assign rdt = mem_rdt;

endmodule

// ==== verif/tcb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_clk_gen (
  output logic sub,
  output logic rst
);

  // 10 ns period
  initial begin
    sub = 1'b0;
    forever #5 sub = ~sub;
  end

  // reset held for 10 rising edges, released on an edge
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge sub);
    rst <= 1'b0;
  end

endmodule

// ==== verif/tcb_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// bound checks on tcb_top: response timing, slice hold, reset, alignment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_asserts (
  input logic                sub,
  input logic                rst,
  input logic                rdy,
  input logic                rsp,
  input logic                m_vld,
  input logic                m_rdy,
  input logic                m_wen,
  input tcb_pkg::adr_t       m_adr,
  input tcb_pkg::siz_t       m_siz,
  input tcb_pkg::ben_t       m_ben,
  input tcb_pkg::dat_t       m_wdt,
  input logic                mem_en,
  input tcb_pkg::ctl_state_t state
);

  import tcb_pkg::*;

  // count of failed assertions
  int unsigned fails = 0;

  logic acc;
  logic mis;
  dat_t wdt_en;

  // controller takes a request
  assign acc = m_vld & m_rdy;
  // address not a multiple of the access size
  assign mis = (int'(m_adr) % (1 << m_siz)) != 0;

  // only enabled write lanes carry defined data in the held copy
  always_comb begin
    for (int i = 0; i < BEN; i++) begin
      wdt_en[8*i +: 8] = (m_wen & m_ben[i]) ? m_wdt[8*i +: 8] : 8'h00;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response timing
  //////////////////////////////////////////////////////////////////////

  rsp_after_acc: assert property (
    @(posedge sub) disable iff (rst) acc |-> ##DLY rsp
  ) else begin
    $error("no response %0d cycle after controller acceptance", DLY);
    fails++;
  end

  // no pulse without a matching acceptance
  rsp_has_acc: assert property (
    @(posedge sub) disable iff (rst) rsp |-> $past(acc, DLY)
  ) else begin
    $error("response pulse without an acceptance %0d cycle earlier", DLY);
    fails++;
  end

  //////////////////////////////////////////////////////////////////////
  // slice hold, reset values, alignment
  //////////////////////////////////////////////////////////////////////

  slice_hold: assert property (
    @(posedge sub) disable iff (rst)
      !rdy |=> rdy || $stable({m_vld, m_wen, m_adr, m_siz, m_ben, wdt_en})
  ) else begin
    $error("slice outputs changed while rdy was low");
    fails++;
  end

  reset_values: assert property (
    @(posedge sub) rst |=> rdy && !rsp && !mem_en && (state == idle)
  ) else begin
    $error("rdy, rsp, mem_en or FSM state wrong after a reset cycle");
    fails++;
  end

  // a misaligned request never reaches the array
  misaligned_no_mem: assert property (
    @(posedge sub) disable iff (rst) acc && mis |-> !mem_en
  ) else begin
    $error("mem_en high for a misaligned request");
    fails++;
  end

endmodule

bind tcb_top tcb_asserts u_asserts (
  .sub    (sub),
  .rst    (rst),
  .rdy    (rdy),
  .rsp    (rsp),
  .m_vld  (m_vld),
  .m_rdy  (m_rdy),
  .m_wen  (m_wen),
  .m_adr  (m_adr),
  .m_siz  (m_siz),
  .m_ben  (m_ben),
  .m_wdt  (m_wdt),
  .mem_en (mem_en),
  .state  (u_ctl.state)
);

// ==== verif/tcb_tb.sv ====
//////////////////////////////////////////////////////////////////////
// TCB subsystem testbench: LFSR stimulus, reference memory, checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_tb;

  import tcb_pkg::*;

  // words in play, small so partial writes keep hitting the same words
  localparam int WIN   = 16;
  localparam int N_PRT = 24;
  localparam int N_B2B = 32;
  localparam int N_MIS = 12;
  localparam int N_REQ = 2*WIN + N_PRT + WIN + N_B2B + WIN + 2*N_MIS;
  // 4 cycles per request, reset, slack for drains and idle windows
  localparam int LIMIT = N_REQ*4 + 10 + 100;

  // expected response, chk set when rdt is compared
  typedef struct packed {
    logic chk;
    logic err;
    dat_t rdt;
  } exp_t;

  logic sub;
  logic rst;
  logic vld;
  logic rdy;
  logic wen;
  adr_t adr;
  siz_t siz;
  ben_t ben;
  dat_t wdt;
  dat_t rdt;
  logic err;
  logic rsp;

  logic [15:0] lfsr = 16'd63624;
  // reference memory, one entry per byte address
  logic [7:0]  ref_mem [WRD*BEN];
  exp_t        exp_q [$];
  exp_t        exp_e;
  string       tname;
  int          errors = 0;
  int          t_err;
  int          tests = 0;
  int          tx_cnt;
  int          rsp_cnt;
  int          tx_tot = 0;
  int          rsp_tot = 0;
  logic        saw_stall;

  tcb_clk_gen u_clk (
    .sub (sub),
    .rst (rst)
  );

  tcb_top DUT (
    .sub (sub),
    .rst (rst),
    .vld (vld),
    .rdy (rdy),
    .wen (wen),
    .adr (adr),
    .siz (siz),
    .ben (ben),
    .wdt (wdt),
    .rdt (rdt),
    .err (err),
    .rsp (rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  // expected response, reference updated in transfer order
  function automatic exp_t model(input logic w, input adr_t a, input siz_t s,
                                 input ben_t b, input dat_t d);
    exp_t e;
    int   base;
    e    = '0;
    base = (int'(a) / BEN) * BEN;
    if ((int'(a) % (1 << s)) != 0) begin
      // misaligned, memory untouched
      e.err = 1'b1;
    end else if (w) begin
      for (int i = 0; i < BEN; i++) begin
        if (b[i]) begin
          ref_mem[base+i] = d[8*i +: 8];
        end
      end
    end else begin
      e.chk = 1'b1;
      for (int i = 0; i < BEN; i++) begin
        e.rdt[8*i +: 8] = ref_mem[base+i];
      end
    end
    return e;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERROR %s %s: expected %h actual %h", tname, what, exp, act);
    errors++;
    t_err++;
  endtask

  // random aligned address in the window and a size of 1, 2 or 4 bytes
  task automatic pick_aligned(output adr_t a, output siz_t s);
    s = siz_t'(rnd(2));
    if (s > 2) begin
      s = 2;
    end
    a = adr_t'(rnd(4) * BEN);
    a = a | adr_t'(rnd(2) & ~((1 << s) - 1));
  endtask

  // one request, held until the transfer edge
  task automatic send(input logic w, input adr_t a, input siz_t s,
                      input ben_t b, input dat_t d);
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    siz <= s;
    ben <= b;
    wdt <= d;
    @(posedge sub);
    while (!rdy) begin
      saw_stall = 1'b1;
      @(posedge sub);
    end
    exp_q.push_back(model(w, a, s, b, d));
    tx_cnt++;
  endtask

  task automatic gap();
    vld <= 1'b0;
    @(posedge sub);
  endtask

  task automatic start_test(input string name);
    tname     = name;
    t_err     = 0;
    tx_cnt    = 0;
    rsp_cnt   = 0;
    saw_stall = 1'b0;
  endtask

  // waits for every response, then reports the test
  task automatic finish_test();
    vld <= 1'b0;
    do begin
      @(negedge sub);
    end while (exp_q.size() != 0);
    // a few quiet cycles so a late extra pulse is still counted
    repeat (DLY + 2) @(negedge sub);
    assert (rsp_cnt == tx_cnt) else report_mismatch("responses", tx_cnt, rsp_cnt);
    $display("test %s: %0d transfers, %0d responses, %0d errors",
             tname, tx_cnt, rsp_cnt, t_err);
    tests++;
    tx_tot  += tx_cnt;
    rsp_tot += rsp_cnt;
    @(posedge sub);
  endtask

  //////////////////////////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////////////////////////

  // every pulse counts, matched or not
  always @(posedge sub) begin
    if (!rst && rsp) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        $display("%s: response pulse with no transfer outstanding", tname);
        errors++;
        t_err++;
      end else begin
        exp_e = exp_q.pop_front();
        assert (err == exp_e.err) else report_mismatch("err", 32'(exp_e.err), 32'(err));
        if (exp_e.chk) begin
          assert (rdt == exp_e.rdt) else report_mismatch("rdt", exp_e.rdt, rdt);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    adr_t pa;
    siz_t ps;
    ben_t pb;
    logic pw;
    int   wi;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    siz = '0;
    ben = '0;
    wdt = '0;
    @(posedge sub);
    while (rst) @(posedge sub);

    // idle after reset, ready and quiet
    start_test("reset");
    assert (rdy === 1'b1) else report_mismatch("rdy", 1, 32'(rdy));
    repeat (8) begin
      @(posedge sub);
      assert (rsp === 1'b0) else report_mismatch("rsp", 0, 32'(rsp));
      assert (rdy === 1'b1) else report_mismatch("rdy", 1, 32'(rdy));
    end
    finish_test();

    // fills the whole window, later tests rely on defined words
    start_test("full_write");
    for (int i = 0; i < WIN; i++) begin
      send(1'b1, adr_t'(i*BEN), 2'd2, 4'hF, rnd(32));
    end
    for (int i = 0; i < WIN; i++) begin
      send(1'b0, adr_t'(i*BEN), 2'd2, 4'hF, '0);
    end
    finish_test();

    start_test("partial_write");
    for (int i = 0; i < N_PRT; i++) begin
      pick_aligned(pa, ps);
      pb = ben_t'(rnd(4));
      pb = pb & ~ben_t'(1 << rnd(2));
      send(1'b1, pa, ps, pb, rnd(32));
      gap();
    end
    for (int i = 0; i < WIN; i++) begin
      send(1'b0, adr_t'(i*BEN), 2'd2, 4'hF, '0);
    end
    finish_test();

    // no gaps, every partial write stalls the next request
    start_test("back_to_back");
    for (int i = 0; i < N_B2B; i++) begin
      pw = 1'(rnd(1));
      pick_aligned(pa, ps);
      pb = ben_t'(rnd(4));
      if (pw) begin
        pb = pb & ~ben_t'(1 << rnd(2));
      end
      send(pw, pa, ps, pb, rnd(32));
    end
    for (int i = 0; i < WIN; i++) begin
      send(1'b0, adr_t'(i*BEN), 2'd2, 4'hF, '0);
    end
    assert (saw_stall) else begin
      $display("%s: rdy never went low under back-to-back partial writes", tname);
      errors++;
      t_err++;
    end
    finish_test();

    // odd address with size 2 or 4, then read the word back
    start_test("misaligned");
    for (int i = 0; i < N_MIS; i++) begin
      wi = int'(rnd(4));
      ps = siz_t'(1 + rnd(1));
      pa = adr_t'(wi*BEN) | adr_t'({rnd(1), 1'b1});
      pw = 1'(rnd(1));
      send(pw, pa, ps, ben_t'(rnd(4)), rnd(32));
      send(1'b0, adr_t'(wi*BEN), 2'd2, 4'hF, '0);
    end
    finish_test();

    $display("tests %0d, transfers %0d, responses %0d, errors %0d, assertion failures %0d",
             tests, tx_tot, rsp_tot, errors, DUT.u_asserts.fails);
    if (errors == 0 && DUT.u_asserts.fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (LIMIT) @(posedge sub);
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== all.f ====
logic/tcb_pkg.sv
logic/tcb_bp_slice.sv
logic/tcb_ctl.sv
logic/tcb_mem.sv
logic/tcb_top.sv
verif/tcb_clk_gen.sv
verif/tcb_asserts.sv
verif/tcb_tb.sv

// ==== Bender.yml ====
package:
  name: tcb_subsystem

sources:
  - logic/tcb_pkg.sv
  - logic/tcb_bp_slice.sv
  - logic/tcb_ctl.sv
  - logic/tcb_mem.sv
  - logic/tcb_top.sv
  - target: test
    files:
      - verif/tcb_clk_gen.sv
      - verif/tcb_asserts.sv
      - verif/tcb_tb.sv
